//--- logic/core_perf_pkg.sv
`default_nettype none

package core_perf_pkg;

    // width shared by every performance counter
    localparam int CTR_WIDTH = 32;

    typedef logic [CTR_WIDTH-1:0] ctr_t;

    // instruction cache port strobes
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } icache_bus_t;

    // one data cache lane, req_rw high for a write
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic req_rw;
        logic rsp_valid;
        logic rsp_ready;
    } dcache_lane_t;

    // all counters reported by the unit
    typedef struct packed {
        ctr_t ifetches;
        ctr_t loads;
        ctr_t stores;
        ctr_t ifetch_latency;
        ctr_t load_latency;
    } perf_counts_t;

    // why the report strobe fired
    typedef enum logic [1:0] {
        cause_none     = 2'd0,
        cause_done     = 2'd1,
        cause_periodic = 2'd2
    } report_cause_e;

endpackage

`default_nettype wire

//--- logic/dcache_lane_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lane_monitor #(
    parameter int NUM_LANES = 4,
    localparam int LANE_CNT_W = $clog2(NUM_LANES + 1)
) (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire core_perf_pkg::dcache_lane_t [NUM_LANES-1:0] dcache,
    output logic [LANE_CNT_W-1:0]                       rd_count,
    output logic [LANE_CNT_W-1:0]                       wr_count,
    output logic [LANE_CNT_W-1:0]                       rsp_count,
    output core_perf_pkg::ctr_t                         stores
);

    logic [NUM_LANES-1:0] rd_fire;
    logic [NUM_LANES-1:0] wr_fire;
    logic [NUM_LANES-1:0] rsp_fire;
    logic [NUM_LANES-1:0] rd_fire_q;
    logic [NUM_LANES-1:0] wr_fire_q;

    // number of set bits in a lane vector
    function automatic logic [LANE_CNT_W-1:0] popcount(input logic [NUM_LANES-1:0] bits);
        logic [LANE_CNT_W-1:0] total;
        total = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            total = total + LANE_CNT_W'(bits[i]);
        end
        return total;
    endfunction

    // per-lane fires, split by direction
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            rd_fire[i]  = dcache[i].req_valid && dcache[i].req_ready && !dcache[i].req_rw;
            wr_fire[i]  = dcache[i].req_valid && dcache[i].req_ready && dcache[i].req_rw;
            rsp_fire[i] = dcache[i].rsp_valid && dcache[i].rsp_ready;
        end
    end

    // request fires go through one register stage
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_fire_q <= '0;
            wr_fire_q <= '0;
        end else begin
            rd_fire_q <= rd_fire;
            wr_fire_q <= wr_fire;
        end
    end

    assign rd_count  = popcount(rd_fire_q);
    assign wr_count  = popcount(wr_fire_q);
    // responses are counted in the cycle they fire
    assign rsp_count = popcount(rsp_fire);

    // store total, one cycle behind wr_count
    always_ff @(posedge clk) begin
        if (reset) begin
            stores <= '0;
        end else begin
            stores <= stores + core_perf_pkg::ctr_t'(wr_count);
        end
    end

endmodule

`default_nettype wire

//--- logic/access_latency_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module access_latency_tracker #(
    parameter int COUNT_WIDTH = 1
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [COUNT_WIDTH-1:0]   issue_count,
    input  wire [COUNT_WIDTH-1:0]   retire_count,
    output core_perf_pkg::ctr_t     accesses,
    output core_perf_pkg::ctr_t     latency
);

    // accesses in flight, may dip below zero when
    // a retire is seen before its issue
    logic signed [core_perf_pkg::CTR_WIDTH-1:0] pending;

    core_perf_pkg::ctr_t issue_ext;
    core_perf_pkg::ctr_t retire_ext;

    assign issue_ext  = core_perf_pkg::ctr_t'(issue_count);
    assign retire_ext = core_perf_pkg::ctr_t'(retire_count);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + $signed(issue_ext) - $signed(retire_ext);
        end
    end

    // every cycle adds the accesses still outstanding,
    // so the sum is total access-cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            latency  <= '0;
            accesses <= '0;
        end else begin
            latency  <= latency + $unsigned(pending);
            accesses <= accesses + issue_ext;
        end
    end

endmodule

`default_nettype wire

//--- logic/report_timer.sv
`timescale 1ns/1ps
`default_nettype none

module report_timer #(
    parameter int REPORT_INTERVAL = 10000,
    localparam int INTERVAL_W = $clog2(REPORT_INTERVAL + 1)
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             busy,
    output logic                            report,
    output core_perf_pkg::report_cause_e    cause
);

    logic                  busy_q;
    logic [INTERVAL_W-1:0] interval_cnt;
    logic                  busy_fell;
    logic                  interval_zero;

    // counts 0..REPORT_INTERVAL, then wraps
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q       <= 1'b0;
            interval_cnt <= '0;
        end else begin
            busy_q <= busy;
            if (interval_cnt == INTERVAL_W'(REPORT_INTERVAL)) begin
                interval_cnt <= '0;
            end else begin
                interval_cnt <= interval_cnt + 1'b1;
            end
        end
    end

    assign busy_fell     = busy_q && !busy;
    assign interval_zero = (interval_cnt == '0);

    assign report = !reset && (busy_fell || interval_zero);

    // done takes priority over a coinciding wrap
    always_comb begin
        if (reset) begin
            cause = core_perf_pkg::cause_none;
        end else if (busy_fell) begin
            cause = core_perf_pkg::cause_done;
        end else if (interval_zero) begin
            cause = core_perf_pkg::cause_periodic;
        end else begin
            cause = core_perf_pkg::cause_none;
        end
    end

endmodule

`default_nettype wire

//--- logic/core_mem_perf.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_perf #(
    parameter int NUM_LANES = 4,
    parameter int REPORT_INTERVAL = 10000,
    localparam int LANE_CNT_W = $clog2(NUM_LANES + 1)
) (
    input  wire                                             clk,
    input  wire                                             reset,
    input  wire core_perf_pkg::icache_bus_t                 icache,
    input  wire core_perf_pkg::dcache_lane_t [NUM_LANES-1:0] dcache,
    input  wire                                             busy,
    output core_perf_pkg::perf_counts_t                     counts,
    output logic                                            report,
    output core_perf_pkg::report_cause_e                    cause
);

    logic icache_req_fire;
    logic icache_rsp_fire;

    logic [LANE_CNT_W-1:0] dcache_rd_count;
    logic [LANE_CNT_W-1:0] dcache_rsp_count;

    core_perf_pkg::ctr_t ifetch_count;
    core_perf_pkg::ctr_t ifetch_latency;
    core_perf_pkg::ctr_t load_count;
    core_perf_pkg::ctr_t load_latency;
    core_perf_pkg::ctr_t store_count;

    // instruction port handshakes
    assign icache_req_fire = icache.req_valid && icache.req_ready;
    assign icache_rsp_fire = icache.rsp_valid && icache.rsp_ready;

    dcache_lane_monitor #(
        .NUM_LANES (NUM_LANES)
    ) dcache_monitor (
        .clk       (clk),
        .reset     (reset),
        .dcache    (dcache),
        .rd_count  (dcache_rd_count),
        // write count is only needed for the store total inside
        .wr_count  (),
        .rsp_count (dcache_rsp_count),
        .stores    (store_count)
    );

    // fetches: one request or response per cycle at most
    access_latency_tracker #(
        .COUNT_WIDTH (1)
    ) ifetch_tracker (
        .clk          (clk),
        .reset        (reset),
        .issue_count  (icache_req_fire),
        .retire_count (icache_rsp_fire),
        .accesses     (ifetch_count),
        .latency      (ifetch_latency)
    );

    // loads issue from the delayed read count
    access_latency_tracker #(
        .COUNT_WIDTH (LANE_CNT_W)
    ) load_tracker (
        .clk          (clk),
        .reset        (reset),
        .issue_count  (dcache_rd_count),
        .retire_count (dcache_rsp_count),
        .accesses     (load_count),
        .latency      (load_latency)
    );

    report_timer #(
        .REPORT_INTERVAL (REPORT_INTERVAL)
    ) timer (
        .clk    (clk),
        .reset  (reset),
        .busy   (busy),
        .report (report),
        .cause  (cause)
    );

    assign counts = '{
        ifetches:       ifetch_count,
        loads:          load_count,
        stores:         store_count,
        ifetch_latency: ifetch_latency,
        load_latency:   load_latency
    };

endmodule

`default_nettype wire

//--- dv/core_mem_perf_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_perf_checker (
    input wire                                  clk,
    input wire                                  reset,
    input wire                                  busy,
    input wire core_perf_pkg::perf_counts_t     counts,
    input wire                                  report,
    input wire core_perf_pkg::report_cause_e    cause
);

    // number of failed properties so far
    int error_count = 0;

    // a cause only ever comes with the strobe
    cause_tracks_report: assert property (@(posedge clk) disable iff (reset)
        (cause == core_perf_pkg::cause_none) == !report)
    else begin
        $error("cause and report strobe disagree");
        error_count++;
    end

    counters_never_decrease: assert property (@(posedge clk) disable iff (reset)
        counts.ifetches >= $past(counts.ifetches) &&
        counts.loads >= $past(counts.loads) &&
        counts.stores >= $past(counts.stores) &&
        counts.ifetch_latency >= $past(counts.ifetch_latency) &&
        counts.load_latency >= $past(counts.load_latency))
    else begin
        $error("a performance counter decreased");
        error_count++;
    end

    // done needs busy high in the cycle before
    done_follows_busy: assert property (@(posedge clk) disable iff (reset)
        (report && cause == core_perf_pkg::cause_done) |-> $past(busy))
    else begin
        $error("done report without busy in the previous cycle");
        error_count++;
    end

endmodule

bind core_mem_perf core_mem_perf_checker checks (
    .clk    (clk),
    .reset  (reset),
    .busy   (busy),
    .counts (counts),
    .report (report),
    .cause  (cause)
);

`default_nettype wire

//--- dv/core_mem_perf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_perf_tb;

    localparam int NUM_LANES = 4;
    localparam int REPORT_INTERVAL = 20;

    // busy stimulus modes
    localparam int BUSY_HIGH = 0;
    localparam int BUSY_RANDOM = 1;
    localparam int BUSY_DROP = 2;

    logic clk;
    logic reset;
    logic busy;
    core_perf_pkg::icache_bus_t icache;
    core_perf_pkg::dcache_lane_t [NUM_LANES-1:0] dcache;
    core_perf_pkg::perf_counts_t counts;
    logic report;
    core_perf_pkg::report_cause_e cause;

    logic [15:0] lfsr = 16'd55;
    string test_name;

    // reference model state
    core_perf_pkg::ctr_t ref_ifetches;
    core_perf_pkg::ctr_t ref_ifetch_lat;
    core_perf_pkg::ctr_t ref_loads;
    core_perf_pkg::ctr_t ref_load_lat;
    core_perf_pkg::ctr_t ref_stores;
    int ref_ifetch_pend;
    int ref_load_pend;
    int ref_rd_q;
    int ref_wr_q;
    int ref_interval;
    logic ref_busy_q;
    logic exp_report = 1'b0;
    core_perf_pkg::report_cause_e exp_cause = core_perf_pkg::cause_none;

    core_mem_perf #(
        .NUM_LANES       (NUM_LANES),
        .REPORT_INTERVAL (REPORT_INTERVAL)
    ) dut_i (
        .clk    (clk),
        .reset  (reset),
        .icache (icache),
        .dcache (dcache),
        .busy   (busy),
        .counts (counts),
        .report (report),
        .cause  (cause)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else stop_with_failure($sformatf("ERR %s/%s: expected %0d, actual %0d",
                                         test_name, name, expected, actual));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic random_bit();
        logic feedback;
        feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [7:0] random_bits(input int width);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[6:0], random_bit()};
        end
        return value;
    endfunction

    // 0 read, 1 write, 2 response
    function automatic int count_lane_fires(input int kind);
        int total;
        total = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            case (kind)
                0: total += int'(dcache[i].req_valid && dcache[i].req_ready && !dcache[i].req_rw);
                1: total += int'(dcache[i].req_valid && dcache[i].req_ready && dcache[i].req_rw);
                default: total += int'(dcache[i].rsp_valid && dcache[i].rsp_ready);
            endcase
        end
        return total;
    endfunction

    // one clock edge of the reference model on the inputs held over it
    task automatic advance_model();
        logic req_fire;
        logic rsp_fire;
        if (reset) begin
            ref_ifetches = '0;
            ref_ifetch_lat = '0;
            ref_loads = '0;
            ref_load_lat = '0;
            ref_stores = '0;
            ref_ifetch_pend = 0;
            ref_load_pend = 0;
            ref_rd_q = 0;
            ref_wr_q = 0;
            ref_interval = 0;
            ref_busy_q = 1'b0;
        end else begin
            req_fire = icache.req_valid && icache.req_ready;
            rsp_fire = icache.rsp_valid && icache.rsp_ready;
            ref_ifetch_lat = ref_ifetch_lat + core_perf_pkg::ctr_t'(ref_ifetch_pend);
            ref_ifetch_pend = ref_ifetch_pend + int'(req_fire) - int'(rsp_fire);
            ref_ifetches = ref_ifetches + core_perf_pkg::ctr_t'(req_fire);
            // loads issue from last cycle's read fires
            ref_load_lat = ref_load_lat + core_perf_pkg::ctr_t'(ref_load_pend);
            ref_load_pend = ref_load_pend + ref_rd_q - count_lane_fires(2);
            ref_loads = ref_loads + core_perf_pkg::ctr_t'(ref_rd_q);
            ref_stores = ref_stores + core_perf_pkg::ctr_t'(ref_wr_q);
            ref_rd_q = count_lane_fires(0);
            ref_wr_q = count_lane_fires(1);
            ref_interval = (ref_interval == REPORT_INTERVAL) ? 0 : ref_interval + 1;
            ref_busy_q = busy;
        end
    endtask

    task automatic drive_inputs(input int busy_ctl);
        int budget;
        core_perf_pkg::dcache_lane_t lane;
        // responses never outrun the accesses in flight
        budget = ref_load_pend + ref_rd_q;
        icache.req_valid = random_bit();
        icache.req_ready = random_bit();
        icache.rsp_valid = random_bit() && (ref_ifetch_pend > 0);
        icache.rsp_ready = random_bit();
        for (int i = 0; i < NUM_LANES; i++) begin
            lane.req_valid = random_bit();
            lane.req_ready = random_bit();
            lane.req_rw = random_bit();
            lane.rsp_valid = random_bit();
            lane.rsp_ready = random_bit();
            if (lane.rsp_valid && lane.rsp_ready) begin
                if (budget > 0) begin
                    budget--;
                end else begin
                    lane.rsp_valid = 1'b0;
                end
            end
            dcache[i] = lane;
        end
        case (busy_ctl)
            BUSY_HIGH: busy = 1'b1;
            BUSY_DROP: busy = 1'b0;
            default: begin
                if (random_bits(4) == 8'd0) begin
                    busy = !busy;
                end
            end
        endcase
    endtask

    task automatic predict_outputs();
        logic fell;
        fell = ref_busy_q && !busy;
        exp_report = !reset && (fell || ref_interval == 0);
        if (reset) begin
            exp_cause = core_perf_pkg::cause_none;
        end else if (fell) begin
            exp_cause = core_perf_pkg::cause_done;
        end else if (ref_interval == 0) begin
            exp_cause = core_perf_pkg::cause_periodic;
        end else begin
            exp_cause = core_perf_pkg::cause_none;
        end
    endtask

    task automatic compare_outputs();
        check_value("ifetches", ref_ifetches, counts.ifetches);
        check_value("ifetch_latency", ref_ifetch_lat, counts.ifetch_latency);
        check_value("loads", ref_loads, counts.loads);
        check_value("stores", ref_stores, counts.stores);
        check_value("load_latency", ref_load_lat, counts.load_latency);
        check_value("cause", 32'(exp_cause), 32'(cause));
        if (dut_i.checks.error_count != 0) begin
            stop_with_failure("an assertion in the bound checker failed");
        end
    endtask

    // inputs move 1 ns after the edge and outputs settle by the falling edge
    task automatic next_cycle(input logic reset_value, input int busy_ctl);
        @(posedge clk);
        #1;
        advance_model();
        reset = reset_value;
        drive_inputs(busy_ctl);
        predict_outputs();
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic wait_for_report(input core_perf_pkg::report_cause_e want,
                                   input int limit, output int waited);
        logic seen;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < limit) begin
            next_cycle(1'b0, BUSY_HIGH);
            waited++;
            seen = report && (cause == want);
        end
        if (!seen) begin
            stop_with_failure($sformatf("no report with cause %s within %0d cycles",
                                        want.name(), limit));
        end
    endtask

    // busy falls in the same cycle the interval counter wraps
    task automatic drop_busy_on_wrap();
        int waited;
        waited = 0;
        do begin
            next_cycle(1'b0, BUSY_HIGH);
            waited++;
        end while (ref_interval != REPORT_INTERVAL && waited < REPORT_INTERVAL + 2);
        if (ref_interval != REPORT_INTERVAL) begin
            stop_with_failure("interval counter never reached its wrap value");
        end else begin
            next_cycle(1'b0, BUSY_DROP);
            check_value("wrap_report", 1, 32'(report));
            check_value("wrap_cause", 32'(core_perf_pkg::cause_done), 32'(cause));
        end
    endtask

    report_matches_model: assert property (@(negedge clk) disable iff (reset)
        report == exp_report)
    else stop_with_failure($sformatf("ERR %s/report: expected %0d, actual %0d",
                                     test_name, exp_report, report));

    initial begin
        int waited;
        clk = 1'b0;
        reset = 1'b1;
        busy = 1'b0;
        icache = '0;
        dcache = '0;
        test_name = "reset";

        next_cycle(1'b1, BUSY_HIGH);
        check_value("report_in_reset", 0, 32'(report));
        next_cycle(1'b0, BUSY_HIGH);
        check_value("first_report", 1, 32'(report));
        check_value("first_cause", 32'(core_perf_pkg::cause_periodic), 32'(cause));

        test_name = "random_traffic";
        repeat (120) next_cycle(1'b0, BUSY_HIGH);

        test_name = "periodic_report";
        wait_for_report(core_perf_pkg::cause_periodic, REPORT_INTERVAL + 2, waited);
        repeat (3) begin
            wait_for_report(core_perf_pkg::cause_periodic, REPORT_INTERVAL + 2, waited);
            check_value("interval", REPORT_INTERVAL + 1, waited);
        end

        test_name = "done_report";
        next_cycle(1'b0, BUSY_DROP);
        check_value("done_report", 1, 32'(report));
        check_value("done_cause", 32'(core_perf_pkg::cause_done), 32'(cause));
        repeat (3) next_cycle(1'b0, BUSY_HIGH);

        test_name = "done_on_wrap";
        drop_busy_on_wrap();

        test_name = "random_busy";
        repeat (160) next_cycle(1'b0, BUSY_RANDOM);
        drop_busy_on_wrap();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/core_perf_pkg.sv
logic/dcache_lane_monitor.sv
logic/access_latency_tracker.sv
logic/report_timer.sv
logic/core_mem_perf.sv
dv/core_mem_perf_checker.sv
dv/core_mem_perf_tb.sv

//--- Bender.yml
package:
  name: core_mem_perf

sources:
  - logic/core_perf_pkg.sv
  - logic/dcache_lane_monitor.sv
  - logic/access_latency_tracker.sv
  - logic/report_timer.sv
  - logic/core_mem_perf.sv
  - target: simulation
    files:
      - dv/core_mem_perf_checker.sv
      - dv/core_mem_perf_tb.sv
